//--- design/vblk_pkg.sv
`default_nettype none

package vblk_pkg;

   typedef logic [31:0] word_t;
   typedef logic [15:0] ring_idx_t;
   typedef logic [1:0]  resp_t;
   typedef logic [63:0] sector_t;

   // mmio register byte offsets
   localparam logic [7:0] REG_MAGIC             = 8'h00;
   localparam logic [7:0] REG_VERSION           = 8'h04;
   localparam logic [7:0] REG_DEVICE_ID         = 8'h08;
   localparam logic [7:0] REG_VENDOR_ID         = 8'h0c;
   localparam logic [7:0] REG_HOST_FEATURES     = 8'h10;
   localparam logic [7:0] REG_HOST_FEATURES_SEL = 8'h14;
   localparam logic [7:0] REG_QUEUE_SEL         = 8'h30;
   localparam logic [7:0] REG_QUEUE_NUM_MAX     = 8'h34;
   localparam logic [7:0] REG_QUEUE_NUM         = 8'h38;
   localparam logic [7:0] REG_QUEUE_PFN         = 8'h40;
   localparam logic [7:0] REG_QUEUE_NOTIFY      = 8'h50;
   localparam logic [7:0] REG_INTERRUPT_STATUS  = 8'h60;
   localparam logic [7:0] REG_INTERRUPT_ACK     = 8'h64;
   localparam logic [7:0] REG_STATUS            = 8'h70;

   localparam word_t MAGIC_VALUE = 32'h7472_6976;
   localparam word_t VERSION     = 32'd1;
   localparam word_t DEVICE_ID   = 32'd2;
   localparam word_t VENDOR_ID   = 32'h554d_4551;

   // legacy ring layout
   localparam int    PAGE_SHIFT      = 12;
   localparam word_t QUEUE_ALIGN     = 32'd4096;
   localparam word_t DESC_BYTES      = 32'd16;
   localparam word_t USED_ELEM_BYTES = 32'd8;

   localparam word_t BLK_T_IN  = 32'd0;
   localparam logic  MEM_READ  = 1'b0;
   localparam logic  MEM_WRITE = 1'b1;

   typedef enum logic [3:0] {
      Q_IDLE, Q_AVAIL_IDX, Q_RING_ENTRY, Q_DESC_ADDR, Q_DESC_NEXT,
      Q_HDR_TYPE, Q_HDR_SEC_LO, Q_HDR_SEC_HI, Q_COPY,
      Q_STATUS, Q_USED_ID, Q_USED_LEN, Q_USED_IDX
   } qstate_e;

   typedef enum logic [2:0] {
      C_IDLE, C_FILL_REQ, C_FILL_WAIT, C_DRAIN_REQ, C_DRAIN_WAIT
   } copy_state_e;

endpackage

`default_nettype wire

//--- design/vblk_mmio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vblk_mmio_regs #(
   parameter int QUEUE_NUM_MAX = 8
) (
   input  wire                  clk,
   input  wire                  rstn,
   input  wire vblk_pkg::word_t core_araddr,
   output logic                 core_arready,
   input  wire                  core_arvalid,
   input  wire [2:0]            core_arprot,
   output vblk_pkg::word_t      core_rdata,
   input  wire                  core_rready,
   output vblk_pkg::resp_t      core_rresp,
   output logic                 core_rvalid,
   input  wire                  core_bready,
   output vblk_pkg::resp_t      core_bresp,
   output logic                 core_bvalid,
   input  wire vblk_pkg::word_t core_awaddr,
   output logic                 core_awready,
   input  wire                  core_awvalid,
   input  wire [2:0]            core_awprot,
   input  wire vblk_pkg::word_t core_wdata,
   output logic                 core_wready,
   input  wire [3:0]            core_wstrb,
   input  wire                  core_wvalid,
   input  wire                  used_done,
   output logic                 notify,
   output vblk_pkg::word_t      queue_pfn,
   output vblk_pkg::word_t      queue_num,
   output logic                 virtio_interrupt
);

   vblk_pkg::word_t host_features_sel;
   vblk_pkg::word_t queue_sel;
   vblk_pkg::word_t device_status;
   logic            irq_status;

   logic [7:0]      aw_addr;
   vblk_pkg::word_t w_data;
   logic [3:0]      w_strb;
   vblk_pkg::word_t wr_mask;
   vblk_pkg::word_t wr_bits;
   vblk_pkg::word_t rd_word;
   logic            wr_fire;

   assign core_rresp       = '0;
   assign core_bresp       = '0;
   assign virtio_interrupt = irq_status;

   // both halves of the write are held and no response is pending
   assign wr_fire = !core_awready && !core_wready && !core_bvalid;
   assign wr_mask = {{8{w_strb[3]}}, {8{w_strb[2]}}, {8{w_strb[1]}}, {8{w_strb[0]}}};
   assign wr_bits = w_data & wr_mask;

   always_comb begin
      rd_word = '0;
      case (core_araddr[7:0])
         vblk_pkg::REG_MAGIC:             rd_word = vblk_pkg::MAGIC_VALUE;
         vblk_pkg::REG_VERSION:           rd_word = vblk_pkg::VERSION;
         vblk_pkg::REG_DEVICE_ID:         rd_word = vblk_pkg::DEVICE_ID;
         vblk_pkg::REG_VENDOR_ID:         rd_word = vblk_pkg::VENDOR_ID;
         // no feature bits offered
         vblk_pkg::REG_HOST_FEATURES:     rd_word = '0;
         vblk_pkg::REG_HOST_FEATURES_SEL: rd_word = host_features_sel;
         vblk_pkg::REG_QUEUE_SEL:         rd_word = queue_sel;
         vblk_pkg::REG_QUEUE_NUM_MAX:
            rd_word = (queue_sel == '0) ? vblk_pkg::word_t'(QUEUE_NUM_MAX) : '0;
         vblk_pkg::REG_QUEUE_NUM:         rd_word = queue_num;
         vblk_pkg::REG_QUEUE_PFN:         rd_word = queue_pfn;
         vblk_pkg::REG_INTERRUPT_STATUS:  rd_word = {31'b0, irq_status};
         vblk_pkg::REG_STATUS:            rd_word = device_status;
         default:                         rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         core_arready      <= 1'b1;
         core_rvalid       <= 1'b0;
         core_awready      <= 1'b1;
         core_wready       <= 1'b1;
         core_bvalid       <= 1'b0;
         notify            <= 1'b0;
         host_features_sel <= '0;
         queue_sel         <= '0;
         queue_num         <= '0;
         queue_pfn         <= '0;
         device_status     <= '0;
         irq_status        <= 1'b0;
      end else begin
         notify <= 1'b0;
         if (core_arvalid && core_arready) begin
            core_arready <= 1'b0;
            core_rvalid  <= 1'b1;
            core_rdata   <= rd_word;
         end
         if (core_rvalid && core_rready) begin
            core_rvalid  <= 1'b0;
            core_arready <= 1'b1;
         end
         if (core_awvalid && core_awready) begin
            core_awready <= 1'b0;
            aw_addr      <= core_awaddr[7:0];
         end
         if (core_wvalid && core_wready) begin
            core_wready <= 1'b0;
            w_data      <= core_wdata;
            w_strb      <= core_wstrb;
         end
         if (wr_fire) begin
            core_bvalid <= 1'b1;
            notify      <= (aw_addr == vblk_pkg::REG_QUEUE_NOTIFY);
            case (aw_addr)
               vblk_pkg::REG_HOST_FEATURES_SEL:
                  host_features_sel <= (host_features_sel & ~wr_mask) | wr_bits;
               vblk_pkg::REG_QUEUE_SEL:     queue_sel <= (queue_sel & ~wr_mask) | wr_bits;
               vblk_pkg::REG_QUEUE_NUM:     queue_num <= (queue_num & ~wr_mask) | wr_bits;
               vblk_pkg::REG_QUEUE_PFN:     queue_pfn <= (queue_pfn & ~wr_mask) | wr_bits;
               vblk_pkg::REG_INTERRUPT_ACK: irq_status <= irq_status & ~wr_bits[0];
               vblk_pkg::REG_STATUS:
                  device_status <= (device_status & ~wr_mask) | wr_bits;
               default: ;
            endcase
         end
         if (core_bvalid && core_bready) begin
            core_bvalid  <= 1'b0;
            core_awready <= 1'b1;
            core_wready  <= 1'b1;
         end
         // a new completion wins over a same-cycle ack
         if (used_done) begin
            irq_status <= 1'b1;
         end
      end
   end

   a_rdata_hold: assert property (@(posedge clk) disable iff (rstn)
      core_rvalid && !core_rready |=> core_rvalid && $stable(core_rdata));

endmodule

`default_nettype wire

//--- design/vblk_queue_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module vblk_queue_ctrl (
   input  wire                  clk,
   input  wire                  rstn,
   input  wire                  notify,
   input  wire vblk_pkg::word_t queue_pfn,
   input  wire vblk_pkg::word_t queue_num,
   output logic                 used_done,
   output logic                 mem_request_enable,
   output logic                 mem_mode,
   output vblk_pkg::word_t      mem_addr,
   output vblk_pkg::word_t      mem_wdata,
   output logic [3:0]           mem_wstrb,
   input  wire                  mem_response_enable,
   input  wire vblk_pkg::word_t mem_data,
   output logic                 copy_start,
   output logic                 copy_to_mem,
   output vblk_pkg::sector_t    sector,
   output vblk_pkg::word_t      buf_addr,
   input  wire                  copy_done,
   input  wire                  cp_mem_request_enable,
   input  wire                  cp_mem_mode,
   input  wire vblk_pkg::word_t cp_mem_addr,
   input  wire vblk_pkg::word_t cp_mem_wdata,
   output logic                 cp_mem_response_enable,
   output vblk_pkg::word_t      cp_mem_data
);

   vblk_pkg::qstate_e   state;
   logic                pending;
   vblk_pkg::ring_idx_t used_idx;
   vblk_pkg::ring_idx_t head;
   vblk_pkg::ring_idx_t desc_idx;
   vblk_pkg::ring_idx_t slot;
   vblk_pkg::ring_idx_t ring_half;
   logic [1:0]          desc_cnt;
   vblk_pkg::word_t     hdr_addr;
   vblk_pkg::word_t     status_addr;

   vblk_pkg::word_t desc_base, avail_base, used_base;
   vblk_pkg::word_t ring_addr, desc_addr, used_elem;
   vblk_pkg::word_t q_addr, q_wdata;
   logic [3:0]      q_wstrb;
   logic            q_mode, q_access, own_req, own_rsp, in_copy;

   ////////////////////////////////////////////////////////////
   // ring layout
   ////////////////////////////////////////////////////////////
   assign desc_base  = queue_pfn << vblk_pkg::PAGE_SHIFT;
   assign avail_base = desc_base + queue_num * vblk_pkg::DESC_BYTES;
   // flags, idx, ring and used_event, then page aligned
   assign used_base  = (avail_base + 32'd6 + 32'd2 * queue_num + vblk_pkg::QUEUE_ALIGN - 32'd1)
                       & ~(vblk_pkg::QUEUE_ALIGN - 32'd1);
   assign slot       = used_idx % queue_num[15:0];
   assign ring_addr  = avail_base + 32'd4 + {15'b0, slot, 1'b0};
   assign ring_half  = ring_addr[1] ? mem_data[31:16] : mem_data[15:0];
   assign desc_addr  = desc_base + vblk_pkg::DESC_BYTES * desc_idx;
   assign used_elem  = used_base + 32'd4 + vblk_pkg::USED_ELEM_BYTES * slot;

   always_comb begin
      q_access = 1'b1;
      q_mode   = vblk_pkg::MEM_READ;
      q_addr   = '0;
      q_wdata  = '0;
      q_wstrb  = 4'b0000;
      case (state)
         vblk_pkg::Q_AVAIL_IDX:  q_addr = avail_base;
         vblk_pkg::Q_RING_ENTRY: q_addr = {ring_addr[31:2], 2'b00};
         vblk_pkg::Q_DESC_ADDR:  q_addr = desc_addr;
         // flags in the low half, next in the high half
         vblk_pkg::Q_DESC_NEXT:  q_addr = desc_addr + 32'd12;
         vblk_pkg::Q_HDR_TYPE:   q_addr = hdr_addr;
         vblk_pkg::Q_HDR_SEC_LO: q_addr = hdr_addr + 32'd8;
         vblk_pkg::Q_HDR_SEC_HI: q_addr = hdr_addr + 32'd12;
         vblk_pkg::Q_STATUS: begin
            q_mode  = vblk_pkg::MEM_WRITE;
            q_addr  = {status_addr[31:2], 2'b00};
            q_wstrb = 4'b0001 << status_addr[1:0];
         end
         vblk_pkg::Q_USED_ID: begin
            q_mode  = vblk_pkg::MEM_WRITE;
            q_addr  = used_elem;
            q_wdata = {16'b0, head};
            q_wstrb = 4'b1111;
         end
         vblk_pkg::Q_USED_LEN: begin
            q_mode  = vblk_pkg::MEM_WRITE;
            q_addr  = used_elem + 32'd4;
            q_wstrb = 4'b1111;
         end
         vblk_pkg::Q_USED_IDX: begin
            q_mode  = vblk_pkg::MEM_WRITE;
            q_addr  = used_base;
            q_wdata = {used_idx + 16'd1, 16'b0};
            q_wstrb = 4'b1100;
         end
         default: q_access = 1'b0;
      endcase
   end

   // copy engine owns the memory port during Q_COPY
   assign in_copy                = (state == vblk_pkg::Q_COPY);
   assign own_req                = q_access && !pending;
   assign own_rsp                = pending && mem_response_enable;
   assign mem_request_enable     = in_copy ? cp_mem_request_enable : own_req;
   assign mem_mode               = in_copy ? cp_mem_mode : q_mode;
   assign mem_addr               = in_copy ? cp_mem_addr : q_addr;
   assign mem_wdata              = in_copy ? cp_mem_wdata : q_wdata;
   assign mem_wstrb              = in_copy ? 4'b1111 : q_wstrb;
   assign cp_mem_response_enable = in_copy && mem_response_enable;
   assign cp_mem_data            = mem_data;

   always_ff @(posedge clk) begin
      if (rstn) begin
         state      <= vblk_pkg::Q_IDLE;
         pending    <= 1'b0;
         used_idx   <= '0;
         copy_start <= 1'b0;
         used_done  <= 1'b0;
      end else begin
         copy_start <= 1'b0;
         used_done  <= 1'b0;
         if (own_req) begin
            pending <= 1'b1;
         end else if (own_rsp) begin
            pending <= 1'b0;
         end
         case (state)
            vblk_pkg::Q_IDLE: if (notify) state <= vblk_pkg::Q_AVAIL_IDX;
            vblk_pkg::Q_AVAIL_IDX: if (own_rsp) begin
               if (mem_data[31:16] != used_idx) begin
                  state <= vblk_pkg::Q_RING_ENTRY;
               end else begin
                  used_done <= 1'b1;
                  state     <= vblk_pkg::Q_IDLE;
               end
            end
            vblk_pkg::Q_RING_ENTRY: if (own_rsp) begin
               head     <= ring_half;
               desc_idx <= ring_half;
               desc_cnt <= 2'd0;
               state    <= vblk_pkg::Q_DESC_ADDR;
            end
            vblk_pkg::Q_DESC_ADDR: if (own_rsp) begin
               case (desc_cnt)
                  2'd0:    hdr_addr <= mem_data;
                  2'd1:    buf_addr <= mem_data;
                  default: status_addr <= mem_data;
               endcase
               state <= (desc_cnt == 2'd2) ? vblk_pkg::Q_HDR_TYPE : vblk_pkg::Q_DESC_NEXT;
            end
            vblk_pkg::Q_DESC_NEXT: if (own_rsp) begin
               desc_idx <= mem_data[31:16];
               desc_cnt <= desc_cnt + 2'd1;
               state    <= vblk_pkg::Q_DESC_ADDR;
            end
            vblk_pkg::Q_HDR_TYPE: if (own_rsp) begin
               copy_to_mem <= (mem_data == vblk_pkg::BLK_T_IN);
               state       <= vblk_pkg::Q_HDR_SEC_LO;
            end
            vblk_pkg::Q_HDR_SEC_LO: if (own_rsp) begin
               sector[31:0] <= mem_data;
               state        <= vblk_pkg::Q_HDR_SEC_HI;
            end
            vblk_pkg::Q_HDR_SEC_HI: if (own_rsp) begin
               sector[63:32] <= mem_data;
               copy_start    <= 1'b1;
               state         <= vblk_pkg::Q_COPY;
            end
            vblk_pkg::Q_COPY:     if (copy_done) state <= vblk_pkg::Q_STATUS;
            vblk_pkg::Q_STATUS:   if (own_rsp) state <= vblk_pkg::Q_USED_ID;
            vblk_pkg::Q_USED_ID:  if (own_rsp) state <= vblk_pkg::Q_USED_LEN;
            vblk_pkg::Q_USED_LEN: if (own_rsp) state <= vblk_pkg::Q_USED_IDX;
            vblk_pkg::Q_USED_IDX: if (own_rsp) begin
               used_idx <= used_idx + 16'd1;
               state    <= vblk_pkg::Q_AVAIL_IDX;
            end
            default: state <= vblk_pkg::Q_IDLE;
         endcase
      end
   end

   // covers both the controller and the forwarded copy requests
   a_one_outstanding: assert property (@(posedge clk) disable iff (rstn)
      mem_request_enable |=> !mem_request_enable until mem_response_enable);

endmodule

`default_nettype wire

//--- design/vblk_sector_copy.sv
`timescale 1ns/10ps
`default_nettype none

module vblk_sector_copy #(
   parameter int SECTOR_WORDS = 128
) (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire                    copy_start,
   input  wire                    copy_to_mem,
   input  wire vblk_pkg::sector_t sector,
   input  wire vblk_pkg::word_t   buf_addr,
   output logic                   copy_done,
   output logic                   cp_mem_request_enable,
   output logic                   cp_mem_mode,
   output vblk_pkg::word_t        cp_mem_addr,
   output vblk_pkg::word_t        cp_mem_wdata,
   input  wire                    cp_mem_response_enable,
   input  wire vblk_pkg::word_t   cp_mem_data,
   output logic                   disk_request_enable,
   output logic                   disk_mode,
   output vblk_pkg::word_t        disk_addr,
   output vblk_pkg::word_t        disk_wdata,
   output logic [3:0]             disk_wstrb,
   input  wire                    disk_response_enable,
   input  wire vblk_pkg::word_t   disk_data
);

   localparam int IDX_W = $clog2(SECTOR_WORDS);

   vblk_pkg::copy_state_e state;
   logic [IDX_W-1:0]      idx;
   vblk_pkg::word_t       buffer [SECTOR_WORDS];

   logic            fill, drain, writing, last;
   logic            src_rsp, dst_rsp;
   vblk_pkg::word_t src_data;

   assign fill    = (state == vblk_pkg::C_FILL_REQ);
   assign drain   = (state == vblk_pkg::C_DRAIN_REQ);
   assign writing = (state == vblk_pkg::C_DRAIN_REQ) || (state == vblk_pkg::C_DRAIN_WAIT);
   assign last    = (idx == IDX_W'(SECTOR_WORDS - 1));

   // disk is the source for IN requests, memory otherwise
   assign disk_request_enable   = copy_to_mem ? fill : drain;
   assign cp_mem_request_enable = copy_to_mem ? drain : fill;
   assign src_rsp  = copy_to_mem ? disk_response_enable : cp_mem_response_enable;
   assign dst_rsp  = copy_to_mem ? cp_mem_response_enable : disk_response_enable;
   assign src_data = copy_to_mem ? disk_data : cp_mem_data;

   assign disk_mode    = writing ? vblk_pkg::MEM_WRITE : vblk_pkg::MEM_READ;
   assign cp_mem_mode  = disk_mode;
   assign disk_addr    = vblk_pkg::word_t'(sector * vblk_pkg::sector_t'(SECTOR_WORDS))
                         + vblk_pkg::word_t'(idx);
   assign cp_mem_addr  = buf_addr + (vblk_pkg::word_t'(idx) << 2);
   assign disk_wdata   = buffer[idx];
   assign cp_mem_wdata = buffer[idx];
   assign disk_wstrb   = 4'b1111;

   always_ff @(posedge clk) begin
      if (state == vblk_pkg::C_FILL_WAIT && src_rsp) begin
         buffer[idx] <= src_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         state     <= vblk_pkg::C_IDLE;
         idx       <= '0;
         copy_done <= 1'b0;
      end else begin
         copy_done <= 1'b0;
         case (state)
            vblk_pkg::C_IDLE: if (copy_start) begin
               idx   <= '0;
               state <= vblk_pkg::C_FILL_REQ;
            end
            vblk_pkg::C_FILL_REQ: state <= vblk_pkg::C_FILL_WAIT;
            vblk_pkg::C_FILL_WAIT: if (src_rsp) begin
               idx   <= last ? '0 : idx + 1'b1;
               state <= last ? vblk_pkg::C_DRAIN_REQ : vblk_pkg::C_FILL_REQ;
            end
            vblk_pkg::C_DRAIN_REQ: state <= vblk_pkg::C_DRAIN_WAIT;
            vblk_pkg::C_DRAIN_WAIT: if (dst_rsp) begin
               if (last) begin
                  copy_done <= 1'b1;
                  state     <= vblk_pkg::C_IDLE;
               end else begin
                  idx   <= idx + 1'b1;
                  state <= vblk_pkg::C_DRAIN_REQ;
               end
            end
            default: state <= vblk_pkg::C_IDLE;
         endcase
      end
   end

   a_start_idle: assert property (@(posedge clk) disable iff (rstn)
      copy_start |-> state == vblk_pkg::C_IDLE);

endmodule

`default_nettype wire

//--- design/vblk_top.sv
`timescale 1ns/10ps
`default_nettype none

module vblk_top #(
   parameter int SECTOR_WORDS  = 128,
   parameter int QUEUE_NUM_MAX = 8
) (
   input  wire                  clk,
   input  wire                  rstn,
   // AXI-lite register window
   input  wire vblk_pkg::word_t core_araddr,
   output logic                 core_arready,
   input  wire                  core_arvalid,
   input  wire [2:0]            core_arprot,
   output vblk_pkg::word_t      core_rdata,
   input  wire                  core_rready,
   output vblk_pkg::resp_t      core_rresp,
   output logic                 core_rvalid,
   input  wire                  core_bready,
   output vblk_pkg::resp_t      core_bresp,
   output logic                 core_bvalid,
   input  wire vblk_pkg::word_t core_awaddr,
   output logic                 core_awready,
   input  wire                  core_awvalid,
   input  wire [2:0]            core_awprot,
   input  wire vblk_pkg::word_t core_wdata,
   output logic                 core_wready,
   input  wire [3:0]            core_wstrb,
   input  wire                  core_wvalid,
   // memory, byte addressed
   output logic                 mem_request_enable,
   output logic                 mem_mode,
   output vblk_pkg::word_t      mem_addr,
   output vblk_pkg::word_t      mem_wdata,
   output logic [3:0]           mem_wstrb,
   input  wire                  mem_response_enable,
   input  wire vblk_pkg::word_t mem_data,
   // disk, word addressed
   output logic                 disk_request_enable,
   output logic                 disk_mode,
   output vblk_pkg::word_t      disk_addr,
   output vblk_pkg::word_t      disk_wdata,
   output logic [3:0]           disk_wstrb,
   input  wire                  disk_response_enable,
   input  wire vblk_pkg::word_t disk_data,
   output logic                 virtio_interrupt
);

   wire                    notify;
   wire                    used_done;
   wire vblk_pkg::word_t   queue_pfn;
   wire vblk_pkg::word_t   queue_num;
   wire                    copy_start;
   wire                    copy_to_mem;
   wire                    copy_done;
   wire vblk_pkg::sector_t sector;
   wire vblk_pkg::word_t   buf_addr;
   wire                    cp_mem_request_enable;
   wire                    cp_mem_mode;
   wire vblk_pkg::word_t   cp_mem_addr;
   wire vblk_pkg::word_t   cp_mem_wdata;
   wire                    cp_mem_response_enable;
   wire vblk_pkg::word_t   cp_mem_data;

   vblk_mmio_regs #(
      .QUEUE_NUM_MAX (QUEUE_NUM_MAX)
   ) i_mmio_regs (.*);

   vblk_queue_ctrl i_queue_ctrl (.*);

   vblk_sector_copy #(
      .SECTOR_WORDS (SECTOR_WORDS)
   ) i_sector_copy (.*);

endmodule

`default_nettype wire

//--- test/tb_vblk_models.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vblk_models (
   input  wire         clk,
   input  wire         rstn,
   input  wire         mem_request_enable,
   input  wire         mem_mode,
   input  wire [31:0]  mem_addr,
   input  wire [31:0]  mem_wdata,
   input  wire [3:0]   mem_wstrb,
   output logic        mem_response_enable,
   output logic [31:0] mem_data,
   input  wire         disk_request_enable,
   input  wire         disk_mode,
   input  wire [31:0]  disk_addr,
   input  wire [31:0]  disk_wdata,
   input  wire [3:0]   disk_wstrb,
   output logic        disk_response_enable,
   output logic [31:0] disk_data,
   output logic        protocol_error,
   output int          mem_writes,
   output int          disk_writes
);

   // word addressed storage, 16 KB of memory and 256 disk words
   logic [31:0] mem  [0:4095];
   logic [31:0] disk [0:255];

   logic [2:0]  mem_cnt, disk_cnt;
   logic        mem_wr_q, disk_wr_q;
   logic [31:0] mem_addr_q, mem_wdata_q, disk_addr_q, disk_wdata_q;
   logic [3:0]  mem_wstrb_q;
   logic [31:0] strb_mask;

   assign strb_mask = {{8{mem_wstrb_q[3]}}, {8{mem_wstrb_q[2]}},
                       {8{mem_wstrb_q[1]}}, {8{mem_wstrb_q[0]}}};

   initial begin
      mem_response_enable  = 1'b0;
      disk_response_enable = 1'b0;
      mem_data             = '0;
      disk_data            = '0;
      protocol_error       = 1'b0;
      mem_writes           = 0;
      disk_writes          = 0;
      mem_cnt              = '0;
      disk_cnt             = '0;
   end

   always @(posedge clk) begin
      mem_response_enable <= 1'b0;
      if (rstn) begin
         mem_cnt <= '0;
      end else begin
         if (mem_cnt != 0) begin
            mem_cnt <= mem_cnt - 3'd1;
            if (mem_cnt == 3'd1) begin
               mem_response_enable <= 1'b1;
               mem_data            <= mem[mem_addr_q[13:2]];
               if (mem_wr_q) begin
                  mem[mem_addr_q[13:2]] <= (mem[mem_addr_q[13:2]] & ~strb_mask)
                                           | (mem_wdata_q & strb_mask);
                  mem_writes <= mem_writes + 1;
               end
            end
         end
         if (mem_request_enable) begin
            mem_wr_q    <= mem_mode;
            mem_addr_q  <= mem_addr;
            mem_wdata_q <= mem_wdata;
            mem_wstrb_q <= mem_wstrb;
            mem_cnt     <= 3'd1 + 3'($urandom % 4);
         end
      end
   end

   always @(posedge clk) begin
      disk_response_enable <= 1'b0;
      if (rstn) begin
         disk_cnt <= '0;
      end else begin
         if (disk_cnt != 0) begin
            disk_cnt <= disk_cnt - 3'd1;
            if (disk_cnt == 3'd1) begin
               disk_response_enable <= 1'b1;
               disk_data            <= disk[disk_addr_q[7:0]];
               if (disk_wr_q) begin
                  disk[disk_addr_q[7:0]] <= disk_wdata_q;
                  disk_writes <= disk_writes + 1;
               end
            end
         end
         if (disk_request_enable) begin
            disk_wr_q    <= disk_mode;
            disk_addr_q  <= disk_addr;
            disk_wdata_q <= disk_wdata;
            disk_cnt     <= 3'd1 + 3'($urandom % 4);
         end
      end
   end

   a_mem_single: assert property (@(posedge clk) disable iff (rstn)
      mem_request_enable |-> mem_cnt == 0)
      else protocol_error = 1'b1;
   // the disk side always writes whole words
   a_disk_request: assert property (@(posedge clk) disable iff (rstn)
      disk_request_enable |-> disk_cnt == 0 && disk_wstrb == 4'b1111)
      else protocol_error = 1'b1;

endmodule

`default_nettype wire

//--- test/tb_vblk.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vblk;

   logic        clk, rstn;
   logic [31:0] core_araddr, core_awaddr, core_wdata, core_rdata;
   logic        core_arvalid, core_rready, core_awvalid, core_wvalid, core_bready;
   logic        core_arready, core_rvalid, core_awready, core_wready, core_bvalid;
   logic [1:0]  core_rresp, core_bresp;
   logic [3:0]  core_wstrb, mem_wstrb, disk_wstrb;
   logic        mem_request_enable, mem_mode, mem_response_enable;
   logic        disk_request_enable, disk_mode, disk_response_enable;
   logic [31:0] mem_addr, mem_wdata, mem_data, disk_addr, disk_wdata, disk_data;
   logic        virtio_interrupt, protocol_error;
   int          mem_writes, disk_writes, mem_wr_before, disk_wr_before;
   logic [31:0] rd;

   vblk_top #(.SECTOR_WORDS(8), .QUEUE_NUM_MAX(8)) i_dut (
      .core_arprot(3'b000), .core_awprot(3'b000), .*);

   tb_vblk_models i_models (.*);

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else
         fail_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
   endtask

   function automatic logic [31:0] mem_fill(input int i);
      return {i[15:0], ~i[15:0]} ^ 32'h3c5a_0000;
   endfunction

   function automatic logic [31:0] disk_fill(input int i);
      return {~i[15:0], i[15:0]} ^ 32'h00d1_5c00;
   endfunction

   // desc word 3 holds flags low and next high
   task automatic set_desc(input int idx, input logic [31:0] addr, input logic [15:0] next);
      i_models.mem[(32'h1000 + 16 * idx) / 4]     = addr;
      i_models.mem[(32'h1000 + 16 * idx) / 4 + 1] = 32'h0;
      i_models.mem[(32'h1000 + 16 * idx) / 4 + 2] = 32'd32;
      i_models.mem[(32'h1000 + 16 * idx) / 4 + 3] = {next, 16'h0001};
   endtask

   task automatic set_header(input logic [31:0] addr, input logic [31:0] kind,
                             input logic [31:0] sec);
      i_models.mem[addr / 4]     = kind;
      i_models.mem[addr / 4 + 1] = 32'h0;
      i_models.mem[addr / 4 + 2] = sec;
      i_models.mem[addr / 4 + 3] = 32'h0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] data);
      @(posedge clk);
      core_arvalid <= 1'b1;
      core_araddr  <= {24'b0, addr};
      @(negedge clk);
      while (!core_arready) @(negedge clk);
      @(posedge clk);
      core_arvalid <= 1'b0;
      // another register on the bus while the response waits
      core_araddr  <= {24'b0, ~addr};
      @(negedge clk);
      while (!core_rvalid) @(negedge clk);
      data = core_rdata;
      check_word("rresp", 32'd0, {30'b0, core_rresp});
      repeat (hold) @(negedge clk);
      @(posedge clk);
      core_rready <= 1'b1;
      @(posedge clk);
      core_rready <= 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input int hold);
      @(posedge clk);
      core_awvalid <= 1'b1;
      core_awaddr  <= {24'b0, addr};
      core_wvalid  <= 1'b1;
      core_wdata   <= data;
      core_wstrb   <= 4'b1111;
      @(negedge clk);
      while (!(core_awready && core_wready)) @(negedge clk);
      @(posedge clk);
      core_awvalid <= 1'b0;
      core_wvalid  <= 1'b0;
      @(negedge clk);
      while (!core_bvalid) @(negedge clk);
      check_word("bresp", 32'd0, {30'b0, core_bresp});
      repeat (hold) @(negedge clk);
      @(posedge clk);
      core_bready <= 1'b1;
      @(posedge clk);
      core_bready <= 1'b0;
   endtask

   task automatic wait_interrupt();
      @(negedge clk);
      while (!virtio_interrupt) @(negedge clk);
   endtask

   //////////////////////////////////////////////////////////////
   // handshake and protocol checks
   //////////////////////////////////////////////////////////////
   a_r_hold: assert property (@(posedge clk) disable iff (rstn)
      core_rvalid && !core_rready |=> core_rvalid && $stable(core_rdata) && !core_arready)
      else fail_run("read response dropped or changed under back-pressure");
   a_b_hold: assert property (@(posedge clk) disable iff (rstn)
      core_bvalid && !core_bready |=> core_bvalid && !core_awready && !core_wready)
      else fail_run("write response dropped or new write accepted under back-pressure");
   a_models: assert property (@(posedge clk) disable iff (rstn) !protocol_error)
      else fail_run("memory or disk request protocol violated");

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // two batches of 8-word copies fit well inside this
   initial begin
      repeat (20000) @(posedge clk);
      fail_run("watchdog expired before the tests finished");
   end

   initial begin
      void'($urandom(32'h7e4f_1376));
      rstn         = 1'b1;
      core_araddr  = '0;
      core_arvalid = 1'b0;
      core_rready  = 1'b0;
      core_awaddr  = '0;
      core_awvalid = 1'b0;
      core_wdata   = '0;
      core_wstrb   = '0;
      core_wvalid  = 1'b0;
      core_bready  = 1'b0;
      for (int i = 0; i < 4096; i++) i_models.mem[i] = mem_fill(i);
      for (int i = 0; i < 256; i++) i_models.disk[i] = disk_fill(i);
      // ring at pfn 1, avail at 0x1080, used at 0x2000
      set_desc(0, 32'h2800, 16'd1);
      set_desc(1, 32'h3000, 16'd2);
      set_desc(2, 32'h2901, 16'd0);
      set_desc(3, 32'h2820, 16'd4);
      set_desc(4, 32'h3100, 16'd5);
      set_desc(5, 32'h2906, 16'd0);
      set_header(32'h2800, 32'd0, 32'd5);
      set_header(32'h2820, 32'd1, 32'd9);
      i_models.mem[32'h2900 / 4] = 32'hffff_ffff;
      i_models.mem[32'h2904 / 4] = 32'hffff_ffff;
      i_models.mem[32'h1080 / 4] = {16'd2, 16'd0};
      i_models.mem[32'h1084 / 4] = {16'd3, 16'd0};
      repeat (10) @(posedge clk);
      rstn <= 1'b0;

      read_reg(8'h00, 0, rd);
      check_word("magic", 32'h7472_6976, rd);
      read_reg(8'h04, 3, rd);
      check_word("version", 32'd1, rd);
      read_reg(8'h08, 0, rd);
      check_word("device_id", 32'd2, rd);
      read_reg(8'h0c, 0, rd);
      check_word("vendor_id", 32'h554d_4551, rd);
      write_reg(8'h30, 32'd1, 3);
      read_reg(8'h34, 0, rd);
      check_word("queue_num_max_sel1", 32'd0, rd);
      write_reg(8'h30, 32'd0, 0);
      read_reg(8'h34, 0, rd);
      check_word("queue_num_max_sel0", 32'd8, rd);
      write_reg(8'h38, 32'd8, 0);
      write_reg(8'h40, 32'd1, 0);
      read_reg(8'h40, 0, rd);
      check_word("queue_pfn", 32'd1, rd);
      write_reg(8'h70, 32'h0000_0007, 0);
      read_reg(8'h70, 2, rd);
      check_word("status", 32'h0000_0007, rd);

      write_reg(8'h50, 32'd0, 0);
      wait_interrupt();
      for (int i = 0; i < 8; i++) begin
         check_word($sformatf("read_req_word%0d", i), disk_fill(40 + i),
                    i_models.mem[32'h3000 / 4 + i]);
         check_word($sformatf("write_req_word%0d", i), mem_fill(32'h3100 / 4 + i),
                    i_models.disk[72 + i]);
      end
      check_word("status_byte_a", 32'hffff_00ff, i_models.mem[32'h2900 / 4]);
      check_word("status_byte_b", 32'hff00_ffff, i_models.mem[32'h2904 / 4]);
      check_word("used_idx", 32'd2, {16'b0, i_models.mem[32'h2000 / 4][31:16]});
      check_word("used_id0", 32'd0, i_models.mem[32'h2004 / 4]);
      check_word("used_id1", 32'd3, i_models.mem[32'h200c / 4]);

      write_reg(8'h64, 32'd1, 0);
      @(negedge clk);
      check_word("irq_after_ack", 32'd0, {31'b0, virtio_interrupt});
      mem_wr_before  = mem_writes;
      disk_wr_before = disk_writes;
      write_reg(8'h50, 32'd0, 0);
      wait_interrupt();
      check_word("empty_notify_mem_writes", mem_wr_before, mem_writes);
      check_word("empty_notify_disk_writes", disk_wr_before, disk_writes);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- vblk.f
design/vblk_pkg.sv
design/vblk_mmio_regs.sv
design/vblk_queue_ctrl.sv
design/vblk_sector_copy.sv
design/vblk_top.sv
test/tb_vblk_models.sv
test/tb_vblk.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and grade on the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_vblk \
   -f vblk.f -o tb_vblk > compile.log 2>&1 \
   || { echo "compile failed, see compile.log"; exit 1; }

./obj_dir/tb_vblk > sim.log 2>&1

grep -qx "No errors" sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
